// ==== adpcma_defs.svh ====
/* Sizes for the six-channel ADPCM-A decoder.
   Slot and step widths are fixed at 3 and 6 bits and do not follow these values. */
`ifndef ADPCMA_DEFS_SVH
`define ADPCMA_DEFS_SVH

// Channel slots per round
`define ADPCMA_CH 6

// Highest step index of the step-size table
`define ADPCMA_STEP_MAX 48

// Decoded sample width
`define ADPCMA_PCM_W 16

// Unsigned increment magnitude out of the LUT
`define ADPCMA_INC_W 12

// Mixer sum, wide enough for six full-scale samples
`define ADPCMA_ACC_W 19

`endif

// ==== adpcma_pkg.sv ====
/* Types shared by the ADPCM-A decoder and its testbench.
   The slot type holds 0..5 only; 6 and 7 are never produced. */
`include "adpcma_defs.svh"

package adpcma_pkg;

    typedef logic [2:0] slot_t;

    // One ADPCM-A nibble, sign on top
    typedef struct packed {
        logic       sign;
        logic [2:0] mag;
    } adpcma_code_t;

    // One round of input, 30 bits
    typedef struct packed {
        logic [`ADPCMA_CH-1:0]         chon;
        adpcma_code_t [`ADPCMA_CH-1:0] code;
    } adpcma_round_t;

    // Sequencer to decoder, 8 bits
    typedef struct packed {
        slot_t        slot;
        adpcma_code_t code;
        logic         chon;
    } dec_in_t;

    // Decoder to mixer, 19 bits
    typedef struct packed {
        slot_t                           slot;
        logic signed [`ADPCMA_PCM_W-1:0] pcm;
    } ch_sample_t;

    // Decoder pipeline stages, also used as ring indices
    typedef enum logic [2:0] {
        STG_I,
        STG_II,
        STG_III,
        STG_IV,
        STG_V,
        STG_VI
    } stage_e;

    // Clamp a wide signed value to the sample range
    function automatic logic signed [`ADPCMA_PCM_W-1:0] sat_pcm(
        input logic signed [`ADPCMA_ACC_W-1:0] x
    );
        localparam logic signed [`ADPCMA_ACC_W-1:0] HI = 32767;
        localparam logic signed [`ADPCMA_ACC_W-1:0] LO = -32768;
        if (x > HI)
            return 16'sh7fff;
        else if (x < LO)
            return 16'sh8000;
        return x[`ADPCMA_PCM_W-1:0];
    endfunction

endpackage

// ==== adpcma_step_lut.sv ====
/* Increment ROM, one cen clock of latency from address to data.
   Steps above 48 read the last row and trip the assertion. */
`include "adpcma_defs.svh"

module adpcma_step_lut (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cen,
    input  logic [5:0]               step,
    input  logic [2:0]               mag,
    output logic [`ADPCMA_INC_W-1:0] inc
);

    localparam int N_STEP = `ADPCMA_STEP_MAX + 1;

    // Standard ADPCM-A step sizes, roughly 1.1x per index
    localparam logic [10:0] STEP_SIZE [N_STEP] = '{
        11'd16,   11'd17,   11'd19,   11'd21,   11'd23,   11'd25,   11'd28,
        11'd31,   11'd34,   11'd37,   11'd41,   11'd45,   11'd50,   11'd55,
        11'd60,   11'd66,   11'd73,   11'd80,   11'd88,   11'd97,   11'd107,
        11'd118,  11'd130,  11'd143,  11'd157,  11'd173,  11'd190,  11'd209,
        11'd230,  11'd253,  11'd279,  11'd307,  11'd337,  11'd371,  11'd408,
        11'd449,  11'd494,  11'd544,  11'd598,  11'd658,  11'd724,  11'd796,
        11'd876,  11'd963,  11'd1060, 11'd1166, 11'd1282, 11'd1411, 11'd1552
    };

    logic [5:0]  idx;
    logic [10:0] size;
    logic [3:0]  mult;
    logic [14:0] prod;

    // Keep the table index in range
    assign idx  = (step > 6'(`ADPCMA_STEP_MAX)) ? 6'(`ADPCMA_STEP_MAX) : step;
    assign size = STEP_SIZE[idx];

    // Eight entries per step: size * (2*mag + 1) / 8
    assign mult = {mag, 1'b1};
    assign prod = size * mult;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inc <= '0;
        end else if (cen) begin
            // Drop three bits for the divide by 8
            inc <= prod[14:3];
        end
    end

    // Step index comes from the decoder ring and must stay in the table
    a_step_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        cen |-> step <= 6'(`ADPCMA_STEP_MAX)
    );

endmodule

// ==== adpcma_decoder.sv ====
/* Six-stage ADPCM-A decoder, one slot per cen clock, state circulates in a 6-entry ring.
   A sample leaves 4 cen clocks after its slot is presented; chon low wipes that channel. */
`include "adpcma_defs.svh"

module adpcma_decoder
    import adpcma_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cen,
    input  dec_in_t    dec_in,
    output ch_sample_t sample,
    output logic       sample_valid
);

    // One ring entry, everything a slot carries between stages
    typedef struct packed {
        logic                            vld;
        slot_t                           slot;
        logic                            chon;
        logic                            sign;
        logic [2:0]                      mag;
        logic [5:0]                      step;
        logic [5:0]                      lut_step;
        logic signed [`ADPCMA_PCM_W-1:0] acc;
    } ring_t;

    // ring[k] is the register in front of stage k
    ring_t ring [`ADPCMA_CH];
    ring_t stage1;

    logic                            started;
    logic                            entry_vld;
    logic [6:0]                      step_sum;
    logic [5:0]                      step_adapt;
    logic [`ADPCMA_INC_W-1:0]        inc;
    logic signed [`ADPCMA_INC_W:0]   inc_mag;
    logic signed [`ADPCMA_INC_W:0]   inc_q;
    logic signed [`ADPCMA_ACC_W-1:0] acc_sum;
    logic signed [`ADPCMA_PCM_W-1:0] acc_next;

    // First slot 0 marks the start of real data
    assign entry_vld = started | (dec_in.slot == '0);

    // Stage I, step adaptation and LUT address
    always_comb begin
        case (dec_in.code.mag)
            3'd4: step_sum = {1'b0, ring[STG_I].step} + 7'd2;
            3'd5: step_sum = {1'b0, ring[STG_I].step} + 7'd5;
            3'd6: step_sum = {1'b0, ring[STG_I].step} + 7'd7;
            3'd7: step_sum = {1'b0, ring[STG_I].step} + 7'd9;
            // mag 0..3 walks down, floored at 0
            default: step_sum = (ring[STG_I].step == '0) ? 7'd0
                                : {1'b0, ring[STG_I].step} - 7'd1;
        endcase
        step_adapt = (step_sum > 7'(`ADPCMA_STEP_MAX)) ? 6'(`ADPCMA_STEP_MAX)
                     : step_sum[5:0];

        stage1.vld  = entry_vld;
        stage1.slot = dec_in.slot;
        stage1.chon = dec_in.chon;
        stage1.sign = dec_in.code.sign;
        stage1.mag  = dec_in.code.mag;
        // Channel off clears its state
        stage1.step     = dec_in.chon ? step_adapt : 6'd0;
        stage1.lut_step = dec_in.chon ? ring[STG_I].step : 6'd0;
        stage1.acc      = dec_in.chon ? ring[STG_I].acc : '0;
    end

    // Stage II, LUT read with the old step
    adpcma_step_lut i_adpcma_step_lut (
        .clk   (clk),
        .rst_n (rst_n),
        .cen   (cen),
        .step  (ring[STG_II].lut_step),
        .mag   (ring[STG_II].mag),
        .inc   (inc)
    );

    assign inc_mag = $signed({1'b0, inc});

    // Stage IV, signed add and clamp
    assign acc_sum  = $signed(ring[STG_IV].acc) + inc_q;
    assign acc_next = ring[STG_IV].chon ? sat_pcm(acc_sum) : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `ADPCMA_CH; i++) begin
                ring[i] <= '0;
            end
            started      <= 1'b0;
            inc_q        <= '0;
            sample       <= '0;
            sample_valid <= 1'b0;
        end else begin
            // Strobe lasts one clock, never during a stall
            sample_valid <= cen && ring[STG_IV].vld;
            if (cen) begin
                started       <= entry_vld;
                ring[STG_II]  <= stage1;
                ring[STG_III] <= ring[STG_II];
                // Stage III, sign applied to the increment
                ring[STG_IV]  <= ring[STG_III];
                inc_q         <= ring[STG_III].sign ? -inc_mag : inc_mag;
                ring[STG_V]     <= ring[STG_IV];
                ring[STG_V].acc <= acc_next;
                sample          <= '{slot: ring[STG_IV].slot, pcm: acc_next};
                // Stages V and VI close the ring
                ring[STG_VI] <= ring[STG_V];
                ring[STG_I]  <= ring[STG_VI];
            end
        end
    end

    // Returning state must belong to the slot the sequencer presents now
    a_ring_slot: assert property (
        @(posedge clk) disable iff (!rst_n)
        cen && ring[STG_I].vld |-> ring[STG_I].slot == dec_in.slot
    );

endmodule

// ==== adpcma_sequencer.sv ====
/* Slot sequencer, latches a whole round at slot 0 with no back-pressure.
   round_in has to be set up before each slot-0 cen clock. */
`include "adpcma_defs.svh"

module adpcma_sequencer
    import adpcma_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          cen,
    input  adpcma_round_t round_in,
    output logic          round_start,
    output dec_in_t       dec_in
);

    localparam slot_t LAST_SLOT = slot_t'(`ADPCMA_CH - 1);

    slot_t         slot;
    adpcma_round_t round_q;
    adpcma_round_t cur_round;

    // Slot 0 uses the incoming round directly
    assign cur_round = (slot == '0) ? round_in : round_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot        <= '0;
            round_q     <= '0;
            round_start <= 1'b0;
            // Looks like the slot before 0 so the decoder waits for real data
            dec_in      <= '{slot: LAST_SLOT, code: '0, chon: 1'b0};
        end else begin
            round_start <= cen && (slot == '0);
            if (cen) begin
                slot <= (slot == LAST_SLOT) ? slot_t'(0) : slot + slot_t'(1);
                if (slot == '0) begin
                    round_q <= round_in;
                end
                dec_in <= '{slot: slot, code: cur_round.code[slot],
                            chon: cur_round.chon[slot]};
            end
        end
    end

    a_slot_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        slot <= LAST_SLOT
    );

endmodule

// ==== adpcma_mixer.sv ====
/* Sums one round of six channel samples into a clamped 16-bit mix.
   Expects slots to arrive in order with slot 5 last. */
`include "adpcma_defs.svh"

module adpcma_mixer
    import adpcma_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst_n,
    input  ch_sample_t                      sample,
    input  logic                            sample_valid,
    output logic signed [`ADPCMA_PCM_W-1:0] mix,
    output logic                            mix_valid
);

    localparam slot_t LAST_SLOT = slot_t'(`ADPCMA_CH - 1);

    logic signed [`ADPCMA_ACC_W-1:0] sum_q;
    logic signed [`ADPCMA_ACC_W-1:0] sum_next;
    logic                            last;

    // Sign-extended running sum
    assign sum_next = sum_q + $signed(sample.pcm);
    assign last     = (sample.slot == LAST_SLOT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_q     <= '0;
            mix       <= '0;
            mix_valid <= 1'b0;
        end else begin
            mix_valid <= sample_valid && last;
            if (sample_valid) begin
                if (last) begin
                    // Close the round, start the next from zero
                    mix   <= sat_pcm(sum_next);
                    sum_q <= '0;
                end else begin
                    sum_q <= sum_next;
                end
            end
        end
    end

endmodule

// ==== adpcma_top.sv ====
/* ADPCM-A decoder top, six channels time-multiplexed on cen.
   Codes arrive as whole rounds; no ROM fetch, volume or pan. */
`include "adpcma_defs.svh"

module adpcma_top
    import adpcma_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            cen,
    input  adpcma_round_t                   round_in,
    output logic                            round_start,
    output ch_sample_t                      sample,
    output logic                            sample_valid,
    output logic signed [`ADPCMA_PCM_W-1:0] mix,
    output logic                            mix_valid
);

    dec_in_t dec_in;

    // Round latch and slot walk
    adpcma_sequencer i_adpcma_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .cen         (cen),
        .round_in    (round_in),
        .round_start (round_start),
        .dec_in      (dec_in)
    );

    adpcma_decoder i_adpcma_decoder (
        .clk          (clk),
        .rst_n        (rst_n),
        .cen          (cen),
        .dec_in       (dec_in),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    // Runs on every clock, paced by sample_valid
    adpcma_mixer i_adpcma_mixer (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample       (sample),
        .sample_valid (sample_valid),
        .mix          (mix),
        .mix_valid    (mix_valid)
    );

endmodule

// ==== tb_adpcma.sv ====
/* Self-checking testbench for the ADPCM-A decoder, table rounds then 20 random rounds.
   round_in changes right after each round_start, so a round is latched at the next one. */
`include "adpcma_defs.svh"

module tb_adpcma
    import adpcma_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_TBL = 14;
    localparam int N_RND = 20;

    logic                            clk;
    logic                            rst_n;
    logic                            cen;
    adpcma_round_t                   round_in;
    logic                            round_start;
    ch_sample_t                      sample;
    logic                            sample_valid;
    logic signed [`ADPCMA_PCM_W-1:0] mix;
    logic                            mix_valid;

    // Reference step sizes
    int step_size [49] = '{
        16, 17, 19, 21, 23, 25, 28, 31, 34, 37, 41, 45, 50, 55, 60, 66, 73,
        80, 88, 97, 107, 118, 130, 143, 157, 173, 190, 209, 230, 253, 279,
        307, 337, 371, 408, 449, 494, 544, 598, 658, 724, 796, 876, 963,
        1060, 1166, 1282, 1411, 1552
    };

    // Stimulus table, codes written as nibbles ch5..ch0
    logic [5:0]  tbl_chon [N_TBL];
    logic [23:0] tbl_code [N_TBL];
    int          tbl_reps [N_TBL];
    int          tbl_stall_at [N_TBL];
    int          tbl_stall_len [N_TBL];

    adpcma_round_t round_q [$];
    adpcma_round_t cur_round;
    int            acc_m [`ADPCMA_CH];
    int            step_m [`ADPCMA_CH];
    int            exp_slot;
    int            exp_sum;
    logic signed [`ADPCMA_PCM_W-1:0] exp_mix;
    logic          mix_pending;
    int            mix_count;
    int            rounds_driven;
    int            seed;
    logic          cen_seen;
    int            cen_edges;

    adpcma_top i_adpcma_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .cen          (cen),
        .round_in     (round_in),
        .round_start  (round_start),
        .sample       (sample),
        .sample_valid (sample_valid),
        .mix          (mix),
        .mix_valid    (mix_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_sample(input string name, input ch_sample_t got,
                                input ch_sample_t exp);
        if (got !== exp)
            fail_now($sformatf(
                "Mismatch at %0t: %s got slot %0d pcm %0d, expected slot %0d pcm %0d",
                $time, name, got.slot, got.pcm, exp.slot, exp.pcm));
    endtask

    task automatic check_mix(input string name, input logic signed [`ADPCMA_PCM_W-1:0] got,
                             input logic signed [`ADPCMA_PCM_W-1:0] exp);
        if (got !== exp)
            fail_now($sformatf("Mismatch at %0t: %s got %0d, expected %0d",
                     $time, name, got, exp));
    endtask

    task automatic check_strobe(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_now($sformatf("Mismatch at %0t: %s got %b, expected %b",
                     $time, name, got, exp));
    endtask

    function automatic int clamp16(input int x);
        if (x > 32767)
            return 32767;
        if (x < -32768)
            return -32768;
        return x;
    endfunction

    // One slot of the reference decoder
    task automatic model_slot(input int s, output ch_sample_t e);
        int mag;
        int inc;
        int nstep;
        e.slot = slot_t'(s);
        if (!cur_round.chon[s]) begin
            acc_m[s]  = 0;
            step_m[s] = 0;
        end else begin
            mag = cur_round.code[s].mag;
            inc = (step_size[step_m[s]] * (2 * mag + 1)) / 8;
            if (cur_round.code[s].sign)
                acc_m[s] = clamp16(acc_m[s] - inc);
            else
                acc_m[s] = clamp16(acc_m[s] + inc);
            case (mag)
                4: nstep = step_m[s] + 2;
                5: nstep = step_m[s] + 5;
                6: nstep = step_m[s] + 7;
                7: nstep = step_m[s] + 9;
                default: nstep = step_m[s] - 1;
            endcase
            step_m[s] = (nstep < 0) ? 0 : (nstep > 48) ? 48 : nstep;
        end
        e.pcm = 16'(acc_m[s]);
    endtask

    // cen value the DUT saw at the last edge
    // Counts cen edges since reset
    always @(posedge clk) begin
        cen_seen = cen;
        if (!rst_n)
            cen_edges = 0;
        else if (cen)
            cen_edges++;
    end

    // Output monitor, sampled mid-cycle
    always @(negedge clk) begin
        ch_sample_t e;
        if (rst_n) begin
            // round_start on the first cen edge and every sixth one after it
            check_strobe("round_start", round_start,
                         cen_seen && (cen_edges % `ADPCMA_CH == 1));
            if (sample_valid && !cen_seen)
                fail_now($sformatf("sample_valid raised at %0t on a clock with cen low",
                         $time));
            if (mix_valid) begin
                if (!mix_pending)
                    fail_now($sformatf("mix_valid at %0t with no finished round", $time));
                check_mix("mix", mix, exp_mix);
                mix_pending = 1'b0;
                mix_count++;
            end
            if (sample_valid) begin
                if (exp_slot == 0) begin
                    // Past the last driven round the same round_in is latched again
                    if (round_q.size() > 0)
                        cur_round = round_q.pop_front();
                    exp_sum = 0;
                end
                model_slot(exp_slot, e);
                check_sample("sample", sample, e);
                exp_sum += acc_m[exp_slot];
                if (exp_slot == `ADPCMA_CH - 1) begin
                    if (mix_pending)
                        fail_now($sformatf("mix_valid for the round before %0t never came",
                                 $time));
                    exp_mix     = 16'(clamp16(exp_sum));
                    mix_pending = 1'b1;
                    exp_slot    = 0;
                end else begin
                    exp_slot++;
                end
            end
        end
    end

    task automatic wait_round_start();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
            if (n > 50)
                fail_now("Timeout: round_start never came");
        end while (!round_start);
    endtask

    // Load one round after its predecessor is latched, with an optional stall
    task automatic apply_round(input adpcma_round_t r, input int stall_at, input int stall_len);
        wait_round_start();
        round_in = r;
        round_q.push_back(r);
        rounds_driven++;
        if (stall_len > 0) begin
            repeat (stall_at) begin
                @(posedge clk);
                #1;
            end
            cen = 1'b0;
            repeat (stall_len) begin
                @(posedge clk);
                #1;
            end
            cen = 1'b1;
        end
    endtask

    task automatic set_entry(input int i, input logic [5:0] chon, input logic [23:0] code,
                             input int reps, input int st_at, input int st_len);
        tbl_chon[i]      = chon;
        tbl_code[i]      = code;
        tbl_reps[i]      = reps;
        tbl_stall_at[i]  = st_at;
        tbl_stall_len[i] = st_len;
    endtask

    initial begin
        adpcma_round_t r;
        int n;
        seed          = 30;
        mix_count     = 0;
        rounds_driven = 0;
        exp_slot      = 0;
        exp_sum       = 0;
        exp_mix       = '0;
        mix_pending   = 1'b0;
        cen_seen      = 1'b0;
        cen_edges     = 0;
        cur_round     = '0;
        for (int c = 0; c < `ADPCMA_CH; c++) begin
            acc_m[c]  = 0;
            step_m[c] = 0;
        end

        set_entry(0, 6'h3f, 24'h765432, 1, 0, 0);
        set_entry(1, 6'h3f, 24'h012345, 2, 2, 3);
        // mag 0 walks the step down to its floor
        set_entry(2, 6'h3f, 24'h000000, 4, 0, 0);
        // All channels ramp up to the ceiling and saturate high
        set_entry(3, 6'h3f, 24'h777777, 16, 1, 2);
        set_entry(4, 6'h3f, 24'h777777, 2, 0, 0);
        set_entry(5, 6'h3f, 24'hffffff, 30, 3, 4);
        // Half the channels off, then back on from step 0
        set_entry(6, 6'h15, 24'h123456, 1, 0, 0);
        set_entry(7, 6'h3f, 24'h444444, 2, 4, 5);
        set_entry(8, 6'h00, 24'h777777, 1, 0, 0);
        set_entry(9, 6'h3f, 24'h89abcd, 1, 0, 0);
        set_entry(10, 6'h2a, 24'h7f7f7f, 4, 4, 5);
        set_entry(11, 6'h3f, 24'h0f0f0f, 3, 0, 0);
        set_entry(12, 6'h3f, 24'h13579b, 2, 0, 6);
        set_entry(13, 6'h3f, 24'h000000, 2, 0, 0);

        // Round zero is all off and sits on round_in through reset
        rst_n    = 1'b0;
        cen      = 1'b0;
        round_in = '0;
        round_q.push_back('0);
        rounds_driven = 1;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Nothing moves until cen comes up
        repeat (3) begin
            @(negedge clk);
            check_strobe("round_start", round_start, 1'b0);
            check_strobe("sample_valid", sample_valid, 1'b0);
            check_strobe("mix_valid", mix_valid, 1'b0);
            check_sample("sample", sample, '0);
            check_mix("mix", mix, '0);
        end
        @(posedge clk);
        #1;
        cen = 1'b1;

        for (int i = 0; i < N_TBL; i++) begin
            for (int k = 0; k < tbl_reps[i]; k++) begin
                r = adpcma_round_t'({tbl_chon[i], tbl_code[i]});
                apply_round(r, tbl_stall_at[i], tbl_stall_len[i]);
            end
        end

        for (int i = 0; i < N_RND; i++) begin
            r = adpcma_round_t'($random(seed));
            apply_round(r, 0, 0);
        end

        // Let the last round drain through the mixer
        n = 0;
        while (mix_count < rounds_driven) begin
            @(posedge clk);
            n++;
            if (n > 200)
                fail_now("Timeout: mix_valid for the last round never came");
        end

        $display("Test passed");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+.
adpcma_pkg.sv
adpcma_step_lut.sv
adpcma_decoder.sv
adpcma_sequencer.sv
adpcma_mixer.sv
adpcma_top.sv
tb_adpcma.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the ADPCM-A decoder testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f src.f \
    --top-module tb_adpcma \
    -o sim_adpcma

# The simulator exits non-zero on $fatal, the log decides the result
./obj_dir/sim_adpcma > sim.log 2>&1 || true
cat sim.log

if grep -q "Test passed" sim.log; then
    exit 0
else
    exit 1
fi
